// File: tri_pkg.sv
package tri_pkg;

  localparam int COORD_W = 32;

  // One signed vertex coordinate.
  typedef logic signed [COORD_W-1:0] coord_t;

  // x in the lowest word, then y, then z.
  typedef logic [3*COORD_W-1:0] vertex_t;

  typedef logic [31:0] sid_t;

  localparam int AXIS_X = 0;
  localparam int AXIS_Y = 1;
  localparam int AXIS_Z = 2;

  // Seeds for the bounding box fold.
  localparam coord_t COORD_MAX = {1'b0, {(COORD_W-1){1'b1}}};
  localparam coord_t COORD_MIN = {1'b1, {(COORD_W-1){1'b0}}};

  // Pulls one axis out of a vertex.
  function automatic coord_t coord_of(input vertex_t v, input int axis);
    return v[axis*COORD_W +: COORD_W];
  endfunction

endpackage

// File: tri_memory.sv
module tri_memory #(
  parameter int NUM_TRIANGLE = 512,
  parameter int MEM_LATENCY = 3
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            wr_en,
  input  logic [$clog2(NUM_TRIANGLE)-1:0] wr_addr,
  input  tri_pkg::vertex_t                wr_v0,
  input  tri_pkg::vertex_t                wr_v1,
  input  tri_pkg::vertex_t                wr_v2,
  input  tri_pkg::sid_t                   wr_sid,
  input  logic [$clog2(NUM_TRIANGLE)-1:0] tri_count,
  input  logic                            mem_en,
  output logic                            mem_rdy,
  output logic                            mem_not_valid,
  output tri_pkg::vertex_t                mem_v0,
  output tri_pkg::vertex_t                mem_v1,
  output tri_pkg::vertex_t                mem_v2,
  output tri_pkg::sid_t                   mem_sid
);

  import tri_pkg::*;

  localparam int IW = $clog2(NUM_TRIANGLE);
  localparam int LW = $clog2(MEM_LATENCY + 1);
  localparam logic [IW:0] FULL_COUNT = (IW+1)'(NUM_TRIANGLE);

  typedef enum logic [1:0] {M_IDLE, M_PEND, M_AHEAD} mem_state_t;

  vertex_t v0_ram [NUM_TRIANGLE];
  vertex_t v1_ram [NUM_TRIANGLE];
  vertex_t v2_ram [NUM_TRIANGLE];
  sid_t    sid_ram [NUM_TRIANGLE];

  mem_state_t    state;
  logic [IW:0]   rd_ptr;
  logic [IW:0]   last_ptr;
  logic [IW-1:0] rd_addr;
  logic [LW-1:0] lat_cnt;
  logic          armed;
  logic          remain;
  logic          fire;

  // A zero count stands for a full memory.
  assign last_ptr = (tri_count == '0) ? FULL_COUNT : {1'b0, tri_count};
  assign remain = armed && (rd_ptr != last_ptr);
  assign mem_not_valid = !remain;
  assign fire = (state != M_IDLE) && (lat_cnt == '0); // Read lands next cycle.

  always_ff @(posedge clk) begin
    if (wr_en) begin
      v0_ram[wr_addr] <= wr_v0;
      v1_ram[wr_addr] <= wr_v1;
      v2_ram[wr_addr] <= wr_v2;
      sid_ram[wr_addr] <= wr_sid;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= M_IDLE;
      rd_ptr <= '0;
      rd_addr <= '0;
      lat_cnt <= '0;
      armed <= 1'b0;
      mem_rdy <= 1'b0;
    end else begin
      mem_rdy <= fire;
      case (state)
        M_IDLE: begin
          if (mem_en && remain) begin
            state <= M_PEND;
            lat_cnt <= LW'(MEM_LATENCY - 2);
            rd_addr <= rd_ptr[IW-1:0];
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        M_PEND: begin
          if (fire) begin
            // One look-ahead read behind every demand read.
            if (remain) begin
              state <= M_AHEAD;
              lat_cnt <= LW'(MEM_LATENCY - 1);
              rd_addr <= rd_ptr[IW-1:0];
              rd_ptr <= rd_ptr + 1'b1;
            end else begin
              state <= M_IDLE;
            end
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        M_AHEAD: begin
          if (fire)
            state <= M_IDLE; // Wait for the next mem_en.
          else
            lat_cnt <= lat_cnt - 1'b1;
        end
        default: state <= M_IDLE;
      endcase
      if (start) begin
        rd_ptr <= '0;
        armed <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      mem_v0 <= v0_ram[rd_addr];
      mem_v1 <= v1_ram[rd_addr];
      mem_v2 <= v2_ram[rd_addr];
      mem_sid <= sid_ram[rd_addr];
    end
  end

endmodule

// File: tri_manager.sv
module tri_manager #(
  parameter int NUM_TRIANGLE = 512
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            mem_rdy,
  input  logic                            fetch,
  input  logic                            mem_not_valid,
  input  tri_pkg::vertex_t                v0_in,
  input  tri_pkg::vertex_t                v1_in,
  input  tri_pkg::vertex_t                v2_in,
  input  tri_pkg::sid_t                   sid_in,
  output logic                            mem_en,
  output logic                            tri_rdy,
  output tri_pkg::vertex_t                v0_out,
  output tri_pkg::vertex_t                v1_out,
  output tri_pkg::vertex_t                v2_out,
  output tri_pkg::sid_t                   sid_out,
  output logic [$clog2(NUM_TRIANGLE)-1:0] triangle_id
);

  import tri_pkg::*;

  localparam int IW = $clog2(NUM_TRIANGLE);
  localparam logic [IW-1:0] LAST_ID = IW'(NUM_TRIANGLE - 1);

  typedef enum logic [1:0] {READY, CAP, LOAD, IDLE} state_t;

  state_t state;
  state_t nxt_state;

  logic ld;
  logic bypass;
  logic ld_buf;

  vertex_t v0_reg;
  vertex_t v1_reg;
  vertex_t v2_reg;
  sid_t    sid_reg;
  vertex_t v0_buf;
  vertex_t v1_buf;
  vertex_t v2_buf;
  sid_t    sid_buf;

  logic [IW-1:0] id_reg;
  logic [IW-1:0] id_nxt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= CAP; // First record is taken without a fetch.
    else
      state <= nxt_state;
  end

  // Output register, fed from memory or from the buffer.
  always_ff @(posedge clk) begin
    if (bypass) begin
      v0_reg <= v0_in;
      v1_reg <= v1_in;
      v2_reg <= v2_in;
      sid_reg <= sid_in;
    end else if (ld) begin
      v0_reg <= v0_buf;
      v1_reg <= v1_buf;
      v2_reg <= v2_buf;
      sid_reg <= sid_buf;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_buf) begin
      v0_buf <= v0_in;
      v1_buf <= v1_in;
      v2_buf <= v2_in;
      sid_buf <= sid_in;
    end
  end

  assign id_nxt = (id_reg == LAST_ID) ? '0 : id_reg + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      id_reg <= '0;
    else if (bypass || ld_buf)
      id_reg <= id_nxt; // Counts every capture from memory.
  end

  always_comb begin
    nxt_state = IDLE;
    mem_en = 1'b0;
    tri_rdy = 1'b0;
    ld = 1'b0;
    bypass = 1'b0;
    ld_buf = 1'b0;
    case (state)
      LOAD: begin
        tri_rdy = 1'b1;
        nxt_state = IDLE;
      end
      CAP: begin
        if (mem_rdy) begin
          bypass = 1'b1;
          nxt_state = LOAD;
        end else begin
          nxt_state = CAP;
          mem_en = !mem_not_valid;
        end
      end
      READY: begin
        if (fetch) begin
          ld = 1'b1;
          nxt_state = LOAD;
        end else begin
          nxt_state = READY;
        end
      end
      default: begin
        if (fetch && mem_rdy) begin
          bypass = 1'b1;
          nxt_state = LOAD;
        end else if (fetch) begin
          nxt_state = CAP;
        end else if (mem_rdy) begin
          ld_buf = 1'b1; // Park the look-ahead record.
          nxt_state = READY;
        end
      end
    endcase
  end

  assign v0_out = v0_reg;
  assign v1_out = v1_reg;
  assign v2_out = v2_reg;
  assign sid_out = sid_reg;
  assign triangle_id = id_reg;

endmodule

// File: scene_bounds.sv
module scene_bounds #(
  parameter int NUM_TRIANGLE = 512
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            hold,
  input  logic [$clog2(NUM_TRIANGLE)-1:0] tri_count,
  input  logic                            tri_rdy,
  input  tri_pkg::vertex_t                v0,
  input  tri_pkg::vertex_t                v1,
  input  tri_pkg::vertex_t                v2,
  output logic                            fetch,
  output logic                            done,
  output logic [$clog2(NUM_TRIANGLE)-1:0] tri_seen,
  output tri_pkg::coord_t                 min_x,
  output tri_pkg::coord_t                 min_y,
  output tri_pkg::coord_t                 min_z,
  output tri_pkg::coord_t                 max_x,
  output tri_pkg::coord_t                 max_y,
  output tri_pkg::coord_t                 max_z
);

  import tri_pkg::*;

  localparam int IW = $clog2(NUM_TRIANGLE);
  localparam logic [IW:0] FULL_COUNT = (IW+1)'(NUM_TRIANGLE);

  typedef enum logic [2:0] {IDLE, KICK, WAIT, NEXT, DONE} state_t;

  state_t state;
  state_t nxt_state;

  logic [IW:0] seen_cnt;
  logic [IW:0] last_cnt;
  logic        all_seen;

  vertex_t vtx [3];
  coord_t  lo [3];
  coord_t  hi [3];
  coord_t  lo_nxt [3];
  coord_t  hi_nxt [3];

  assign last_cnt = (tri_count == '0) ? FULL_COUNT : {1'b0, tri_count}; // Zero means full.
  assign all_seen = (seen_cnt == last_cnt);

  assign vtx[0] = v0;
  assign vtx[1] = v1;
  assign vtx[2] = v2;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    fetch = 1'b0;
    case (state)
      KICK: begin
        fetch = 1'b1;
        nxt_state = WAIT;
      end
      WAIT: begin
        if (tri_rdy)
          nxt_state = NEXT;
      end
      NEXT: begin
        if (all_seen) begin
          nxt_state = DONE;
        end else if (!hold) begin
          fetch = 1'b1;
          nxt_state = WAIT;
        end
      end
      IDLE, DONE: nxt_state = state;
      default: nxt_state = IDLE;
    endcase
    if (start)
      nxt_state = KICK;
  end

  assign done = (state == DONE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      seen_cnt <= '0;
    else if (start)
      seen_cnt <= '0;
    else if (tri_rdy)
      seen_cnt <= seen_cnt + 1'b1;
  end

  assign tri_seen = seen_cnt[IW-1:0];

  // Signed fold of all three vertices per axis.
  always_comb begin
    for (int a = 0; a < 3; a++) begin
      lo_nxt[a] = lo[a];
      hi_nxt[a] = hi[a];
      for (int k = 0; k < 3; k++) begin
        if (coord_of(vtx[k], a) < lo_nxt[a])
          lo_nxt[a] = coord_of(vtx[k], a);
        if (coord_of(vtx[k], a) > hi_nxt[a])
          hi_nxt[a] = coord_of(vtx[k], a);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int a = 0; a < 3; a++) begin
      if (start) begin
        lo[a] <= COORD_MAX;
        hi[a] <= COORD_MIN;
      end else if (tri_rdy) begin
        lo[a] <= lo_nxt[a];
        hi[a] <= hi_nxt[a];
      end
    end
  end

  assign min_x = lo[AXIS_X];
  assign min_y = lo[AXIS_Y];
  assign min_z = lo[AXIS_Z];
  assign max_x = hi[AXIS_X];
  assign max_y = hi[AXIS_Y];
  assign max_z = hi[AXIS_Z];

endmodule

// File: tri_fetch_top.sv
module tri_fetch_top #(
  parameter int NUM_TRIANGLE = 512,
  parameter int MEM_LATENCY = 3
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            hold,
  input  logic [$clog2(NUM_TRIANGLE)-1:0] tri_count,
  input  logic                            wr_en,
  input  logic [$clog2(NUM_TRIANGLE)-1:0] wr_addr,
  input  tri_pkg::vertex_t                wr_v0,
  input  tri_pkg::vertex_t                wr_v1,
  input  tri_pkg::vertex_t                wr_v2,
  input  tri_pkg::sid_t                   wr_sid,
  output logic                            tri_rdy,
  output logic [$clog2(NUM_TRIANGLE)-1:0] triangle_id,
  output tri_pkg::vertex_t                v0_out,
  output tri_pkg::vertex_t                v1_out,
  output tri_pkg::vertex_t                v2_out,
  output tri_pkg::sid_t                   sid_out,
  output logic                            done,
  output logic [$clog2(NUM_TRIANGLE)-1:0] tri_seen,
  output tri_pkg::coord_t                 min_x,
  output tri_pkg::coord_t                 min_y,
  output tri_pkg::coord_t                 min_z,
  output tri_pkg::coord_t                 max_x,
  output tri_pkg::coord_t                 max_y,
  output tri_pkg::coord_t                 max_z
);

  import tri_pkg::*;

  logic    mem_en;
  logic    mem_rdy;
  logic    mem_not_valid;
  logic    fetch;
  vertex_t mem_v0;
  vertex_t mem_v1;
  vertex_t mem_v2;
  sid_t    mem_sid;

  tri_memory #(
    .NUM_TRIANGLE (NUM_TRIANGLE),
    .MEM_LATENCY  (MEM_LATENCY)
  ) u_memory (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_v0         (wr_v0),
    .wr_v1         (wr_v1),
    .wr_v2         (wr_v2),
    .wr_sid        (wr_sid),
    .tri_count     (tri_count),
    .mem_en        (mem_en),
    .mem_rdy       (mem_rdy),
    .mem_not_valid (mem_not_valid),
    .mem_v0        (mem_v0),
    .mem_v1        (mem_v1),
    .mem_v2        (mem_v2),
    .mem_sid       (mem_sid)
  );

  tri_manager #(
    .NUM_TRIANGLE (NUM_TRIANGLE)
  ) u_manager (
    .clk           (clk),
    .rst           (rst),
    .mem_rdy       (mem_rdy),
    .fetch         (fetch),
    .mem_not_valid (mem_not_valid),
    .v0_in         (mem_v0),
    .v1_in         (mem_v1),
    .v2_in         (mem_v2),
    .sid_in        (mem_sid),
    .mem_en        (mem_en),
    .tri_rdy       (tri_rdy),
    .v0_out        (v0_out),
    .v1_out        (v1_out),
    .v2_out        (v2_out),
    .sid_out       (sid_out),
    .triangle_id   (triangle_id)
  );

  // Consumer sees the same record the outputs carry.
  scene_bounds #(
    .NUM_TRIANGLE (NUM_TRIANGLE)
  ) u_bounds (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .hold      (hold),
    .tri_count (tri_count),
    .tri_rdy   (tri_rdy),
    .v0        (v0_out),
    .v1        (v1_out),
    .v2        (v2_out),
    .fetch     (fetch),
    .done      (done),
    .tri_seen  (tri_seen),
    .min_x     (min_x),
    .min_y     (min_y),
    .min_z     (min_z),
    .max_x     (max_x),
    .max_y     (max_y),
    .max_z     (max_z)
  );

endmodule

// File: tri_fetch_props.sv
module tri_manager_props (
  input logic clk,
  input logic rst,
  input logic tri_rdy,
  input logic mem_en,
  input logic mem_not_valid,
  input logic fetch
);

  // A record is presented for one cycle only.
  rdy_single: assert property (@(posedge clk) disable iff (rst) tri_rdy |=> !tri_rdy)
    else $error("tri_rdy high on two consecutive cycles");

  en_valid: assert property (@(posedge clk) disable iff (rst) !(mem_en && mem_not_valid))
    else $error("mem_en raised while memory has no valid record");

  // Consumer waits for the record before asking again.
  fetch_apart: assert property (@(posedge clk) disable iff (rst) !(fetch && tri_rdy))
    else $error("fetch raised in a tri_rdy cycle");

endmodule

bind tri_manager tri_manager_props u_props (
  .clk           (clk),
  .rst           (rst),
  .tri_rdy       (tri_rdy),
  .mem_en        (mem_en),
  .mem_not_valid (mem_not_valid),
  .fetch         (fetch)
);

// File: tb_tri_fetch.sv
module tb_tri_fetch;

  import tri_pkg::*;

  localparam int NUM_TRIANGLE = 64;
  localparam int MEM_LATENCY = 3;
  localparam int IW = $clog2(NUM_TRIANGLE);
  localparam int NUM_SCENES = 9;
  localparam int SCENE_SIZE [NUM_SCENES] = '{1, 20, 30, 5, 9, 12, 16, 64, 64};

  logic          clk;
  logic          rst;
  logic          start;
  logic          hold;
  logic [IW-1:0] tri_count;
  logic          wr_en;
  logic [IW-1:0] wr_addr;
  vertex_t       wr_v0;
  vertex_t       wr_v1;
  vertex_t       wr_v2;
  sid_t          wr_sid;
  logic          tri_rdy;
  logic [IW-1:0] triangle_id;
  vertex_t       v0_out;
  vertex_t       v1_out;
  vertex_t       v2_out;
  sid_t          sid_out;
  logic          done;
  logic [IW-1:0] tri_seen;
  coord_t        min_x;
  coord_t        min_y;
  coord_t        min_z;
  coord_t        max_x;
  coord_t        max_y;
  coord_t        max_z;

  // Scene model.
  vertex_t rec_v0 [NUM_TRIANGLE];
  vertex_t rec_v1 [NUM_TRIANGLE];
  vertex_t rec_v2 [NUM_TRIANGLE];
  sid_t    rec_sid [NUM_TRIANGLE];
  coord_t  exp_lo [3];
  coord_t  exp_hi [3];
  int      scene_n;
  int      next_rec;
  int      delivered; // Since reset, across scenes.

  integer seed;
  int     errors;
  int     err_mark;
  int     tests_run;
  int     tests_failed;
  int     cycles;
  int     limit;

  tri_fetch_top #(
    .NUM_TRIANGLE (NUM_TRIANGLE),
    .MEM_LATENCY  (MEM_LATENCY)
  ) UUT (
    .clk (clk), .rst (rst), .start (start), .hold (hold), .tri_count (tri_count),
    .wr_en (wr_en), .wr_addr (wr_addr), .wr_v0 (wr_v0), .wr_v1 (wr_v1), .wr_v2 (wr_v2),
    .wr_sid (wr_sid), .tri_rdy (tri_rdy), .triangle_id (triangle_id),
    .v0_out (v0_out), .v1_out (v1_out), .v2_out (v2_out), .sid_out (sid_out),
    .done (done), .tri_seen (tri_seen),
    .min_x (min_x), .min_y (min_y), .min_z (min_z),
    .max_x (max_x), .max_y (max_y), .max_z (max_z)
  );

  always #20 clk = ~clk;

  task automatic check_vertex(input string name, input vertex_t got, input vertex_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_sid(input string name, input sid_t got, input sid_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [IW-1:0] got,
                             input logic [IW-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_pulses(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  function automatic int timeout_limit();
    int sum;
    sum = 0;
    for (int s = 0; s < NUM_SCENES; s++)
      sum += SCENE_SIZE[s] * (MEM_LATENCY + 12) + 200;
    return sum;
  endfunction

  // Signed, so about half come out negative.
  task automatic gen_coord(output coord_t c);
    c = $random(seed);
  endtask

  task automatic gen_vertex(output vertex_t v);
    coord_t x;
    coord_t y;
    coord_t z;
    gen_coord(x);
    gen_coord(y);
    gen_coord(z);
    v = {z, y, x};
  endtask

  task automatic model_bounds(input int n);
    coord_t  c;
    vertex_t v;
    for (int a = 0; a < 3; a++) begin
      exp_lo[a] = rec_v0[0][a*32 +: 32];
      exp_hi[a] = exp_lo[a];
      for (int i = 0; i < n; i++) begin
        for (int k = 0; k < 3; k++) begin
          v = (k == 0) ? rec_v0[i] : (k == 1) ? rec_v1[i] : rec_v2[i];
          c = v[a*32 +: 32];
          if (c < exp_lo[a])
            exp_lo[a] = c;
          if (c > exp_hi[a])
            exp_hi[a] = c;
        end
      end
    end
  endtask

  task automatic run_scene(input int n, input bit rand_hold, input bit new_data,
                           input bit extremes);
    if (new_data) begin
      for (int i = 0; i < n; i++) begin
        gen_vertex(rec_v0[i]);
        gen_vertex(rec_v1[i]);
        gen_vertex(rec_v2[i]);
        if (rec_v2[i] == rec_v0[i])
          rec_v2[i][0] = ~rec_v2[i][0];
        rec_sid[i] = $random(seed);
      end
      if (extremes) begin
        rec_v0[0][31:0] = 32'h7fffffff; // Largest x.
        rec_v1[1][63:32] = 32'h80000000; // Smallest y.
      end
      for (int i = 0; i < n; i++) begin
        @(posedge clk);
        #2;
        wr_en = 1'b1;
        wr_addr = IW'(i);
        wr_v0 = rec_v0[i];
        wr_v1 = rec_v1[i];
        wr_v2 = rec_v2[i];
        wr_sid = rec_sid[i];
      end
    end
    model_bounds(n);
    scene_n = n;
    next_rec = 0;
    @(posedge clk);
    #2;
    wr_en = 1'b0;
    tri_count = IW'(n); // 64 wraps to zero.
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    do begin
      @(posedge clk);
      #2;
      hold = rand_hold ? $random(seed) & 1 : 1'b0;
      @(negedge clk);
    end while (!done);
    hold = 1'b0;
    check_count("tri_seen", tri_seen, tri_count);
    check_coord("min_x", min_x, exp_lo[0]);
    check_coord("min_y", min_y, exp_lo[1]);
    check_coord("min_z", min_z, exp_lo[2]);
    check_coord("max_x", max_x, exp_hi[0]);
    check_coord("max_y", max_y, exp_hi[1]);
    check_coord("max_z", max_z, exp_hi[2]);
    repeat (10) @(posedge clk); // Catch stray pulses.
    check_pulses("tri_rdy pulses", next_rec, n);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Checks every presented record against the model.
  always @(negedge clk) begin : monitor
    logic [IW-1:0] exp_id;
    if (!rst && tri_rdy) begin
      exp_id = IW'((delivered + 1) % NUM_TRIANGLE);
      if (next_rec >= scene_n) begin
        errors++;
        $display("tri_rdy pulsed at %0t with no record left in the scene", $time);
      end else begin
        check_vertex("v0_out", v0_out, rec_v0[next_rec]);
        check_vertex("v1_out", v1_out, rec_v1[next_rec]);
        check_vertex("v2_out", v2_out, rec_v2[next_rec]);
        check_sid("sid_out", sid_out, rec_sid[next_rec]);
        if (v0_out == v2_out) begin
          errors++;
          $display("v0_out and v2_out carry the same vertex at %0t", $time);
        end
      end
      check_count("triangle_id", triangle_id, exp_id);
      next_rec++;
      delivered++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    seed = 32'h6f65;
    limit = timeout_limit();
    {errors, err_mark, tests_run, tests_failed, cycles} = '0;
    {scene_n, next_rec, delivered} = '0;
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    hold = 1'b0;
    tri_count = '0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_v0 = '0;
    wr_v1 = '0;
    wr_v2 = '0;
    wr_sid = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    run_scene(SCENE_SIZE[0], 1'b0, 1'b1, 1'b0);
    end_test("single record scene");
    run_scene(SCENE_SIZE[1], 1'b0, 1'b1, 1'b0);
    end_test("record order and content");
    run_scene(SCENE_SIZE[2], 1'b1, 1'b1, 1'b0);
    end_test("back-pressure");
    run_scene(SCENE_SIZE[3], 1'b0, 1'b1, 1'b0);
    run_scene(SCENE_SIZE[4], 1'b1, 1'b1, 1'b0);
    run_scene(SCENE_SIZE[5], 1'b0, 1'b1, 1'b0);
    end_test("running id over three scenes");
    run_scene(SCENE_SIZE[6], 1'b0, 1'b1, 1'b1);
    end_test("bounds with extreme values");
    run_scene(SCENE_SIZE[7], 1'b0, 1'b1, 1'b0);
    run_scene(SCENE_SIZE[8], 1'b1, 1'b0, 1'b0); // Same records again.
    end_test("full depth and re-run");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: src.f
tri_pkg.sv
tri_memory.sv
tri_manager.sv
scene_bounds.sv
tri_fetch_top.sv
tri_fetch_props.sv
tb_tri_fetch.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tri_fetch \
  -f src.f -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation ended with an error status"
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
